//--- project.f
verilog/wt_cache_pkg.sv
verilog/axi_defs_pkg.sv
verilog/wb_write_port.sv
verilog/write_buffer.sv
verilog/axi_write_ctrl.sv
verilog/wt_write_top.sv
sim/axi_write_checker.sv
sim/write_scoreboard.sv
sim/tb_top.sv

//--- run_sim.sh
#!/bin/bash
# build and run the write-through back end testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
   -f project.f -o tb_sim --Mdir obj_dir > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1

grep -q "^Result: PASSED$" sim.log \
   && { echo "simulation passed"; exit 0; } \
   || { echo "simulation failed, see sim.log"; exit 1; }

//--- sim/axi_write_checker.sv
`timescale 1ns/1ps

module axi_write_checker #(
   parameter int FE_ADDR_W = wt_cache_pkg::FE_ADDR_W,
   parameter int BE_DATA_W = wt_cache_pkg::BE_DATA_W
) (
   input logic                   clk_i,
   input logic                   reset,
   input logic                   awvalid_i,
   input logic                   awready_i,
   input logic [FE_ADDR_W-1:0]   awaddr_i,
   input logic [7:0]             awlen_i,
   input logic                   wvalid_i,
   input logic                   wready_i,
   input logic [BE_DATA_W-1:0]   wdata_i,
   input logic [BE_DATA_W/8-1:0] wstrb_i,
   input logic                   wlast_i
);

   // address phase holds until accepted
   assert property (@(posedge clk_i) disable iff (reset)
      (awvalid_i && !awready_i) |=> (awvalid_i && $stable(awaddr_i)))
      else $error("awvalid dropped or awaddr changed before awready");

   assert property (@(posedge clk_i) disable iff (reset)
      (wvalid_i && !wready_i) |=> (wvalid_i && $stable(wdata_i) && $stable(wstrb_i)))
      else $error("wvalid dropped or write payload changed before wready");

   assert property (@(posedge clk_i) disable iff (reset) wlast_i == wvalid_i)
      else $error("wlast differs from wvalid");

   assert property (@(posedge clk_i) disable iff (reset) awvalid_i |-> awlen_i == 8'd0)
      else $error("awlen is not zero for a single beat write");

endmodule

bind axi_write_ctrl axi_write_checker u_axi_chk (
   .clk_i     (clk_i),
   .reset     (reset),
   .awvalid_i (m_axi_awvalid_o),
   .awready_i (m_axi_awready_i),
   .awaddr_i  (m_axi_awaddr_o),
   .awlen_i   (m_axi_awlen_o),
   .wvalid_i  (m_axi_wvalid_o),
   .wready_i  (m_axi_wready_i),
   .wdata_i   (m_axi_wdata_o),
   .wstrb_i   (m_axi_wstrb_o),
   .wlast_i   (m_axi_wlast_o)
);

//--- sim/tb_top.sv
`timescale 1ns/1ps

module tb_top;

   localparam int ADDR_W   = wt_cache_pkg::FE_ADDR_W;
   localparam int FE_W     = wt_cache_pkg::FE_DATA_W;
   localparam int BE_W     = wt_cache_pkg::BE_DATA_W;
   localparam int FE_BYTES = FE_W / 8;
   localparam int BE_BYTES = BE_W / 8;
   localparam int RATIO    = BE_W / FE_W;
   localparam int MAX_PAT  = 64;
   localparam int PAT_W    = ADDR_W + FE_W + 16;  // addr, data, sel, err, gap

   logic                clk_i = 1'b0;
   logic                reset;
   logic                wb_cyc, wb_stb, wb_we, wb_ack;
   logic [ADDR_W-1:0]   wb_adr;
   logic [FE_W-1:0]     wb_dat;
   logic [FE_BYTES-1:0] wb_sel;
   logic [ADDR_W-1:0]   awaddr;
   logic [7:0]          awlen;
   logic [2:0]          awsize;
   logic [1:0]          awburst, bresp;
   logic                awvalid, awready, wvalid, wready, wlast, bvalid, bready, idle;
   logic [BE_W-1:0]     wdata;
   logic [BE_BYTES-1:0] wstrb;

   logic [PAT_W-1:0]    patterns [MAX_PAT];
   logic                err_done [MAX_PAT];
   logic [BE_W-1:0]     exp_mem [logic [ADDR_W-1:0]];
   logic [BE_W-1:0]     slave_mem [logic [ADDR_W-1:0]];
   logic [31:0]         lcg_state = 32'hb386_2ae8;
   int                  n_pat = 0;
   int                  n_err_pat = 0;
   int                  end_errors = 0;
   int                  sb_errors, ack_count, okay_count, aw_count, pending;

   always #4 clk_i = ~clk_i;

   wt_write_top uut (
      .clk_i (clk_i), .reset (reset),
      .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat), .wb_sel_i (wb_sel), .wb_ack_o (wb_ack),
      .m_axi_awaddr_o (awaddr), .m_axi_awlen_o (awlen), .m_axi_awsize_o (awsize),
      .m_axi_awburst_o (awburst), .m_axi_awvalid_o (awvalid), .m_axi_awready_i (awready),
      .m_axi_wdata_o (wdata), .m_axi_wstrb_o (wstrb), .m_axi_wlast_o (wlast),
      .m_axi_wvalid_o (wvalid), .m_axi_wready_i (wready), .m_axi_bvalid_i (bvalid),
      .m_axi_bresp_i (bresp), .m_axi_bready_o (bready), .idle_o (idle)
   );

   write_scoreboard sb (
      .clk_i (clk_i), .reset (reset), .wb_ack_i (wb_ack), .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat), .wb_sel_i (wb_sel), .awvalid_i (awvalid), .awready_i (awready),
      .awaddr_i (awaddr), .awlen_i (awlen), .awsize_i (awsize), .awburst_i (awburst),
      .wvalid_i (wvalid), .wready_i (wready), .wdata_i (wdata), .wstrb_i (wstrb),
      .bvalid_i (bvalid), .bready_i (bready), .bresp_i (bresp),
      .error_count_o (sb_errors), .ack_count_o (ack_count), .okay_count_o (okay_count),
      .aw_count_o (aw_count), .pending_o (pending)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic slave_delay();  // 0 to 7 cycles
      int d;
      lcg_state = lcg_next(lcg_state);
      d = int'(lcg_state[18:16]);
      repeat (d) @(negedge clk_i);
   endtask

   function automatic logic [BE_W-1:0] merge_bytes(input logic [BE_W-1:0] old,
         input logic [BE_W-1:0] data, input logic [BE_BYTES-1:0] strb);
      logic [BE_W-1:0] r;
      r = old;
      for (int i = 0; i < BE_BYTES; i++) begin
         if (strb[i]) r[8*i +: 8] = data[8*i +: 8];
      end
      return r;
   endfunction

   // expected memory image, byte by byte from each pattern
   task automatic build_image();
      logic [ADDR_W-1:0] adr, word;
      logic [FE_W-1:0]   dat;
      logic [BE_W-1:0]   img;
      int                lane;
      for (int k = 0; k < n_pat; k++) begin
         adr  = patterns[k][PAT_W-1 -: ADDR_W];
         dat  = patterns[k][FE_W+15 -: FE_W];
         word = adr - (adr % BE_BYTES);
         img  = exp_mem.exists(word) ? exp_mem[word] : '0;
         for (int b = 0; b < FE_BYTES; b++) begin
            lane = int'((adr / FE_BYTES) % RATIO) * FE_BYTES + b;
            if (patterns[k][12+b]) img[8*lane +: 8] = dat[8*b +: 8];
         end
         exp_mem[word] = img;
         if (patterns[k][8]) n_err_pat++;
      end
   endtask

   task automatic wb_write(input logic [PAT_W-1:0] p);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b1;
      wb_adr = p[PAT_W-1 -: ADDR_W];
      wb_dat = p[FE_W+15 -: FE_W];
      wb_sel = p[12 +: FE_BYTES];
      @(negedge clk_i);
      while (!wb_ack) @(negedge clk_i);
      if (p[7:0] != 8'd0) begin
         wb_cyc = 1'b0;
         wb_stb = 1'b0;
         wb_we  = 1'b0;
         repeat (int'(p[7:0])) @(negedge clk_i);
      end
   endtask

   // AXI slave: random ready delays, one SLVERR per flagged entry
   initial begin : axi_slave
      int                entry;
      logic [ADDR_W-1:0] a;
      logic [BE_W-1:0]   d;
      logic [BE_BYTES-1:0] s;
      logic              give_err;
      entry = 0;
      @(negedge reset);
      forever begin
         @(negedge clk_i);
         if (awvalid) begin
            slave_delay();
            awready = 1'b1;
            a = awaddr;
            @(negedge clk_i);
            awready = 1'b0;
            while (!wvalid) @(negedge clk_i);
            slave_delay();
            wready = 1'b1;
            d = wdata;
            s = wstrb;
            @(negedge clk_i);
            wready = 1'b0;
            slave_delay();
            give_err = patterns[entry][8] && !err_done[entry];
            bresp  = give_err ? axi_defs_pkg::RESP_SLVERR : axi_defs_pkg::RESP_OKAY;
            bvalid = 1'b1;
            @(negedge clk_i);
            bvalid = 1'b0;
            if (give_err) begin
               err_done[entry] = 1'b1;
            end else begin
               slave_mem[a] = merge_bytes(slave_mem.exists(a) ? slave_mem[a] : '0, d, s);
               entry++;
            end
         end
      end
   end

   initial begin : watchdog
      @(negedge reset);
      repeat (n_pat * 200) @(posedge clk_i);
      $display("timeout: writes did not complete within %0d cycles", n_pat * 200);
      $display("Result: FAILED");
      $finish;
   end

   initial begin : main
      reset = 1'b1;
      {wb_cyc, wb_stb, wb_we} = 3'b000;
      wb_adr = '0;
      wb_dat = '0;
      wb_sel = '0;
      {awready, wready, bvalid} = 3'b000;
      bresp = axi_defs_pkg::RESP_OKAY;
      for (int k = 0; k < MAX_PAT; k++) begin
         patterns[k] = '1;  // end marker
         err_done[k] = 1'b0;
      end
      $readmemh("sim/write_patterns.mem", patterns);
      while (n_pat < MAX_PAT && patterns[n_pat] != '1) n_pat++;
      build_image();
      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      reset = 1'b0;
      @(negedge clk_i);
      if (!idle) begin
         $display("idle_o is low after reset");
         end_errors++;
      end
      for (int k = 0; k < n_pat; k++) wb_write(patterns[k]);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      wait (okay_count == n_pat);
      @(negedge clk_i);
      if (!idle) begin
         $display("idle_o is low after the final OKAY");
         end_errors++;
      end
      if (ack_count != n_pat || okay_count != ack_count || pending != 0) begin
         $display("%0d patterns, %0d acks, %0d OKAYs, %0d still pending",
                  n_pat, ack_count, okay_count, pending);
         end_errors++;
      end
      if (aw_count != n_pat + n_err_pat) begin
         $display("%0d address phases seen where %0d belong", aw_count, n_pat + n_err_pat);
         end_errors++;
      end
      if (slave_mem.size() != exp_mem.size()) begin
         $display("memory holds %0d words instead of %0d", slave_mem.size(), exp_mem.size());
         end_errors++;
      end
      foreach (exp_mem[w]) begin
         if (!slave_mem.exists(w) || slave_mem[w] !== exp_mem[w]) begin
            $display("MISMATCH at %0t: mem[%h] expected %h got %h", $time, w, exp_mem[w],
                     slave_mem.exists(w) ? slave_mem[w] : '0);
            end_errors++;
         end
      end
      $display("scoreboard errors %0d, end of run errors %0d", sb_errors, end_errors);
      if (sb_errors == 0 && end_errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- sim/write_patterns.mem
// one write per line, 20 hex digits:
// address(8) data(8) wb_sel(1) error flag(1) idle gap in cycles(2)
00001000112233440f03
0000100455667788f002
00001008a5a5a5a51001
0000100c5a5a5a5a6000
00001010deadbeeff104
0000200001020304f000
0000200405060708f000
00002008090a0b0cf000
0000200c0d0e0f10f000
0000201011121314f000
0000201415161718f000
00001000ffeeddcc8002
00003004cafef00d3100
000030000badf00dc005
0000100413579bdf2001
0000300824681357f000

//--- sim/write_scoreboard.sv
`timescale 1ns/1ps

module write_scoreboard #(
   parameter int FE_ADDR_W = wt_cache_pkg::FE_ADDR_W,
   parameter int FE_DATA_W = wt_cache_pkg::FE_DATA_W,
   parameter int BE_DATA_W = wt_cache_pkg::BE_DATA_W
) (
   input  logic                   clk_i,
   input  logic                   reset,
   input  logic                   wb_ack_i,
   input  logic [FE_ADDR_W-1:0]   wb_adr_i,
   input  logic [FE_DATA_W-1:0]   wb_dat_i,
   input  logic [FE_DATA_W/8-1:0] wb_sel_i,
   input  logic                   awvalid_i,
   input  logic                   awready_i,
   input  logic [FE_ADDR_W-1:0]   awaddr_i,
   input  logic [7:0]             awlen_i,
   input  logic [2:0]             awsize_i,
   input  logic [1:0]             awburst_i,
   input  logic                   wvalid_i,
   input  logic                   wready_i,
   input  logic [BE_DATA_W-1:0]   wdata_i,
   input  logic [BE_DATA_W/8-1:0] wstrb_i,
   input  logic                   bvalid_i,
   input  logic                   bready_i,
   input  logic [1:0]             bresp_i,
   output int                     error_count_o,
   output int                     ack_count_o,
   output int                     okay_count_o,
   output int                     aw_count_o,
   output int                     pending_o
);

   localparam int FE_BYTES = FE_DATA_W / 8;
   localparam int BE_BYTES = BE_DATA_W / 8;
   localparam int RATIO    = BE_DATA_W / FE_DATA_W;

   logic [FE_ADDR_W-1:0]  exp_addr_q [$];
   logic [BE_DATA_W-1:0]  exp_data_q [$];
   logic [BE_BYTES-1:0]   exp_strb_q [$];
   logic [FE_ADDR_W-1:0]   req_adr;  // request as seen on the previous edge
   logic [FE_DATA_W-1:0]   req_dat;
   logic [FE_DATA_W/8-1:0] req_sel;
   int errors = 0;
   int acks   = 0;
   int okays  = 0;
   int aws    = 0;

   assign error_count_o = errors;
   assign ack_count_o   = acks;
   assign okay_count_o  = okays;
   assign aw_count_o    = aws;
   assign pending_o     = exp_addr_q.size();

   task automatic compare_value(input string name, input logic [BE_DATA_W-1:0] expv,
                                input logic [BE_DATA_W-1:0] actv);
      if (expv !== actv) begin
         $display("MISMATCH at %0t: %s expected %h got %h", $time, name, expv, actv);
         errors++;
      end
   endtask

   always @(posedge clk_i) begin
      int pos;
      if (!reset) begin
         // ack belongs to the request taken on the edge before
         if (wb_ack_i) begin
            pos = int'(req_adr / FE_BYTES) % RATIO;
            exp_addr_q.push_back(req_adr & ~FE_ADDR_W'(BE_BYTES - 1));
            exp_data_q.push_back({RATIO{req_dat}});
            exp_strb_q.push_back(BE_BYTES'(req_sel) << (pos * FE_BYTES));
            acks++;
         end
         if (awvalid_i && awready_i) begin
            aws++;
            if (exp_addr_q.size() == 0) begin
               $display("address phase at %0t with no acked write pending", $time);
               errors++;
            end else begin
               compare_value("awaddr", BE_DATA_W'(exp_addr_q[0]), BE_DATA_W'(awaddr_i));
               compare_value("awlen", '0, BE_DATA_W'(awlen_i));
               compare_value("awsize", BE_DATA_W'($clog2(BE_BYTES)), BE_DATA_W'(awsize_i));
               compare_value("awburst", BE_DATA_W'(axi_defs_pkg::BURST_FIXED),
                             BE_DATA_W'(awburst_i));
            end
         end
         if (wvalid_i && wready_i && exp_data_q.size() != 0) begin
            compare_value("wdata", exp_data_q[0], wdata_i);
            compare_value("wstrb", BE_DATA_W'(exp_strb_q[0]), BE_DATA_W'(wstrb_i));
         end
         // only OKAY retires the oldest write
         if (bvalid_i && bready_i && bresp_i == axi_defs_pkg::RESP_OKAY) begin
            if (exp_addr_q.size() == 0) begin
               $display("OKAY response at %0t with no write pending", $time);
               errors++;
            end else begin
               void'(exp_addr_q.pop_front());
               void'(exp_data_q.pop_front());
               void'(exp_strb_q.pop_front());
               okays++;
            end
         end
      end
      req_adr <= wb_adr_i;
      req_dat <= wb_dat_i;
      req_sel <= wb_sel_i;
   end

endmodule

//--- verilog/axi_defs_pkg.sv
package axi_defs_pkg;

   // burst type codes
   localparam logic [1:0] BURST_FIXED = 2'b00;
   localparam logic [1:0] BURST_INCR  = 2'b01;

   // write response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- verilog/axi_write_ctrl.sv
`timescale 1ns/1ps

module axi_write_ctrl #(
   parameter int FE_ADDR_W = wt_cache_pkg::FE_ADDR_W,
   parameter int BE_DATA_W = wt_cache_pkg::BE_DATA_W
) (
   input  logic                                        clk_i,
   input  logic                                        reset,
   input  logic                                        empty_i,
   input  logic                                        one_left_i,
   input  logic [FE_ADDR_W-$clog2(BE_DATA_W/8)-1:0]    head_addr_i,
   input  logic [BE_DATA_W-1:0]                        head_data_i,
   input  logic [BE_DATA_W/8-1:0]                      head_strb_i,
   output logic                                        pop_o,
   output logic                                        idle_o,
   output logic [FE_ADDR_W-1:0]                        m_axi_awaddr_o,
   output logic [7:0]                                  m_axi_awlen_o,
   output logic [2:0]                                  m_axi_awsize_o,
   output logic [1:0]                                  m_axi_awburst_o,
   output logic                                        m_axi_awvalid_o,
   input  logic                                        m_axi_awready_i,
   output logic [BE_DATA_W-1:0]                        m_axi_wdata_o,
   output logic [BE_DATA_W/8-1:0]                      m_axi_wstrb_o,
   output logic                                        m_axi_wlast_o,
   output logic                                        m_axi_wvalid_o,
   input  logic                                        m_axi_wready_i,
   input  logic                                        m_axi_bvalid_i,
   input  logic [1:0]                                  m_axi_bresp_i,
   output logic                                        m_axi_bready_o
);

   localparam int BE_BYTES = BE_DATA_W / 8;
   localparam int BE_OFF_W = $clog2(BE_BYTES);

   typedef enum logic [1:0] {
      IDLE,
      ADDR,
      DATA,
      RESP
   } state_t;

   state_t state;
   state_t state_next;
   logic   resp_ok;
   logic   resp_err;

   assign resp_ok  = m_axi_bvalid_i & (m_axi_bresp_i == axi_defs_pkg::RESP_OKAY);
   assign resp_err = m_axi_bvalid_i & (m_axi_bresp_i != axi_defs_pkg::RESP_OKAY);

   // single beat, full memory word
   assign m_axi_awlen_o   = 8'd0;
   assign m_axi_awsize_o  = 3'(BE_OFF_W);
   assign m_axi_awburst_o = axi_defs_pkg::BURST_FIXED;

   // payload comes straight from the buffer head, which only moves on pop
   assign m_axi_awaddr_o = {head_addr_i, {BE_OFF_W{1'b0}}};
   assign m_axi_wdata_o  = head_data_i;
   assign m_axi_wstrb_o  = head_strb_i;

   assign m_axi_awvalid_o = (state == ADDR);
   assign m_axi_wvalid_o  = (state == DATA);
   assign m_axi_wlast_o   = m_axi_wvalid_o;  // every burst is one beat
   assign m_axi_bready_o  = (state == RESP);

   assign pop_o  = (state == RESP) & resp_ok;  // only OKAY retires the head
   assign idle_o = (state == IDLE) & empty_i;

   always_comb begin
      state_next = state;
      case (state)
         IDLE: begin
            if (!empty_i) state_next = ADDR;
         end
         ADDR: begin
            if (m_axi_awready_i) state_next = DATA;
         end
         DATA: begin
            if (m_axi_wready_i) state_next = RESP;
         end
         RESP: begin
            if (resp_ok) begin
               state_next = one_left_i ? IDLE : ADDR;  // more entries waiting
            end else if (resp_err) begin
               state_next = ADDR;  // resend same head
            end
         end
         default: state_next = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         state <= state_next;
      end
   end

endmodule

//--- verilog/wb_write_port.sv
`timescale 1ns/1ps

module wb_write_port #(
   parameter int FE_ADDR_W = wt_cache_pkg::FE_ADDR_W,
   parameter int FE_DATA_W = wt_cache_pkg::FE_DATA_W,
   parameter int BE_DATA_W = wt_cache_pkg::BE_DATA_W
) (
   input  logic                                        clk_i,
   input  logic                                        reset,
   input  logic                                        wb_cyc_i,
   input  logic                                        wb_stb_i,
   input  logic                                        wb_we_i,
   input  logic [FE_ADDR_W-1:0]                        wb_adr_i,
   input  logic [FE_DATA_W-1:0]                        wb_dat_i,
   input  logic [FE_DATA_W/8-1:0]                      wb_sel_i,
   output logic                                        wb_ack_o,
   input  logic                                        full_i,
   output logic                                        push_o,
   output logic [FE_ADDR_W-$clog2(BE_DATA_W/8)-1:0]    push_addr_o,
   output logic [BE_DATA_W-1:0]                        push_data_o,
   output logic [BE_DATA_W/8-1:0]                      push_strb_o
);

   localparam int FE_BYTES = FE_DATA_W / 8;
   localparam int BE_BYTES = BE_DATA_W / 8;
   localparam int FE_OFF_W = $clog2(FE_BYTES);
   localparam int BE_OFF_W = $clog2(BE_BYTES);
   localparam int RATIO    = BE_DATA_W / FE_DATA_W;  // fe words per memory word

   logic                 wb_req;
   logic [FE_ADDR_W-1:0] word_pos;

   // a request already acked this cycle is not taken twice
   assign wb_req = wb_cyc_i & wb_stb_i & wb_we_i & ~wb_ack_o;
   assign push_o = wb_req & ~full_i;  // full buffer holds back the ack

   // fe word slot inside the memory word
   assign word_pos = (wb_adr_i >> FE_OFF_W) & FE_ADDR_W'(RATIO - 1);

   assign push_addr_o = wb_adr_i[FE_ADDR_W-1:BE_OFF_W];
   assign push_data_o = {RATIO{wb_dat_i}};  // same data on every lane
   assign push_strb_o = BE_BYTES'(wb_sel_i) << (word_pos * FE_BYTES);

   // ack goes out on the edge that writes the buffer
   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         wb_ack_o <= 1'b0;
      end else begin
         wb_ack_o <= push_o;
      end
   end

endmodule

//--- verilog/write_buffer.sv
`timescale 1ns/1ps

module write_buffer #(
   parameter int FE_ADDR_W   = wt_cache_pkg::FE_ADDR_W,
   parameter int BE_DATA_W   = wt_cache_pkg::BE_DATA_W,
   parameter int BUF_DEPTH_W = wt_cache_pkg::BUF_DEPTH_W
) (
   input  logic                                        clk_i,
   input  logic                                        reset,
   input  logic                                        push_i,
   input  logic [FE_ADDR_W-$clog2(BE_DATA_W/8)-1:0]    push_addr_i,
   input  logic [BE_DATA_W-1:0]                        push_data_i,
   input  logic [BE_DATA_W/8-1:0]                      push_strb_i,
   input  logic                                        pop_i,
   output logic [FE_ADDR_W-$clog2(BE_DATA_W/8)-1:0]    head_addr_o,
   output logic [BE_DATA_W-1:0]                        head_data_o,
   output logic [BE_DATA_W/8-1:0]                      head_strb_o,
   output logic                                        full_o,
   output logic                                        empty_o,
   output logic                                        one_left_o
);

   localparam int WADDR_W = FE_ADDR_W - $clog2(BE_DATA_W / 8);
   localparam int DEPTH   = 2 ** BUF_DEPTH_W;

   logic [WADDR_W-1:0]     addr_mem [DEPTH];
   logic [BE_DATA_W-1:0]   data_mem [DEPTH];
   logic [BE_DATA_W/8-1:0] strb_mem [DEPTH];
   logic [BUF_DEPTH_W-1:0] wr_ptr;
   logic [BUF_DEPTH_W-1:0] rd_ptr;
   logic [BUF_DEPTH_W:0]   count;  // one extra bit to tell full from empty
   logic                   do_push;
   logic                   do_pop;

   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;

   assign full_o     = (count == (BUF_DEPTH_W+1)'(DEPTH));
   assign empty_o    = (count == '0);
   assign one_left_o = (count == (BUF_DEPTH_W+1)'(1));  // retiring this empties it

   // head shown without a read cycle
   assign head_addr_o = addr_mem[rd_ptr];
   assign head_data_o = data_mem[rd_ptr];
   assign head_strb_o = strb_mem[rd_ptr];

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         addr_mem[wr_ptr] <= push_addr_i;
         data_mem[wr_ptr] <= push_data_i;
         strb_mem[wr_ptr] <= push_strb_i;
      end
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         if (do_push & ~do_pop) count <= count + 1'b1;
         else if (do_pop & ~do_push) count <= count - 1'b1;
      end
   end

endmodule

//--- verilog/wt_cache_pkg.sv
package wt_cache_pkg;

   // processor side: byte address and data width
   localparam int FE_ADDR_W = 32;
   localparam int FE_DATA_W = 32;

   // memory side word, a power-of-two multiple of FE_DATA_W
   localparam int BE_DATA_W = 64;

   // log2 of write buffer depth
   localparam int BUF_DEPTH_W = 2;  // 4 entries

endpackage

//--- verilog/wt_write_top.sv
`timescale 1ns/1ps

module wt_write_top #(
   parameter int FE_ADDR_W   = wt_cache_pkg::FE_ADDR_W,
   parameter int FE_DATA_W   = wt_cache_pkg::FE_DATA_W,
   parameter int BE_DATA_W   = wt_cache_pkg::BE_DATA_W,
   parameter int BUF_DEPTH_W = wt_cache_pkg::BUF_DEPTH_W
) (
   input  logic                     clk_i,
   input  logic                     reset,
   input  logic                     wb_cyc_i,
   input  logic                     wb_stb_i,
   input  logic                     wb_we_i,
   input  logic [FE_ADDR_W-1:0]     wb_adr_i,
   input  logic [FE_DATA_W-1:0]     wb_dat_i,
   input  logic [FE_DATA_W/8-1:0]   wb_sel_i,
   output logic                     wb_ack_o,
   output logic [FE_ADDR_W-1:0]     m_axi_awaddr_o,
   output logic [7:0]               m_axi_awlen_o,
   output logic [2:0]               m_axi_awsize_o,
   output logic [1:0]               m_axi_awburst_o,
   output logic                     m_axi_awvalid_o,
   input  logic                     m_axi_awready_i,
   output logic [BE_DATA_W-1:0]     m_axi_wdata_o,
   output logic [BE_DATA_W/8-1:0]   m_axi_wstrb_o,
   output logic                     m_axi_wlast_o,
   output logic                     m_axi_wvalid_o,
   input  logic                     m_axi_wready_i,
   input  logic                     m_axi_bvalid_i,
   input  logic [1:0]               m_axi_bresp_i,
   output logic                     m_axi_bready_o,
   output logic                     idle_o
);

   localparam int WADDR_W = FE_ADDR_W - $clog2(BE_DATA_W / 8);  // memory word address

   logic                   push;
   logic [WADDR_W-1:0]     push_addr;
   logic [BE_DATA_W-1:0]   push_data;
   logic [BE_DATA_W/8-1:0] push_strb;
   logic                   pop;
   logic [WADDR_W-1:0]     head_addr;
   logic [BE_DATA_W-1:0]   head_data;
   logic [BE_DATA_W/8-1:0] head_strb;
   logic                   buf_full;
   logic                   buf_empty;
   logic                   buf_one_left;

   wb_write_port #(
      .FE_ADDR_W (FE_ADDR_W),
      .FE_DATA_W (FE_DATA_W),
      .BE_DATA_W (BE_DATA_W)
   ) u_wb_port (
      .clk_i       (clk_i),
      .reset       (reset),
      .wb_cyc_i    (wb_cyc_i),
      .wb_stb_i    (wb_stb_i),
      .wb_we_i     (wb_we_i),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .wb_sel_i    (wb_sel_i),
      .wb_ack_o    (wb_ack_o),
      .full_i      (buf_full),
      .push_o      (push),
      .push_addr_o (push_addr),
      .push_data_o (push_data),
      .push_strb_o (push_strb)
   );

   write_buffer #(
      .FE_ADDR_W   (FE_ADDR_W),
      .BE_DATA_W   (BE_DATA_W),
      .BUF_DEPTH_W (BUF_DEPTH_W)
   ) u_buffer (
      .clk_i       (clk_i),
      .reset       (reset),
      .push_i      (push),
      .push_addr_i (push_addr),
      .push_data_i (push_data),
      .push_strb_i (push_strb),
      .pop_i       (pop),
      .head_addr_o (head_addr),
      .head_data_o (head_data),
      .head_strb_o (head_strb),
      .full_o      (buf_full),
      .empty_o     (buf_empty),
      .one_left_o  (buf_one_left)
   );

   axi_write_ctrl #(
      .FE_ADDR_W (FE_ADDR_W),
      .BE_DATA_W (BE_DATA_W)
   ) u_ctrl (
      .clk_i           (clk_i),
      .reset           (reset),
      .empty_i         (buf_empty),
      .one_left_i      (buf_one_left),
      .head_addr_i     (head_addr),
      .head_data_i     (head_data),
      .head_strb_i     (head_strb),
      .pop_o           (pop),
      .idle_o          (idle_o),
      .m_axi_awaddr_o  (m_axi_awaddr_o),
      .m_axi_awlen_o   (m_axi_awlen_o),
      .m_axi_awsize_o  (m_axi_awsize_o),
      .m_axi_awburst_o (m_axi_awburst_o),
      .m_axi_awvalid_o (m_axi_awvalid_o),
      .m_axi_awready_i (m_axi_awready_i),
      .m_axi_wdata_o   (m_axi_wdata_o),
      .m_axi_wstrb_o   (m_axi_wstrb_o),
      .m_axi_wlast_o   (m_axi_wlast_o),
      .m_axi_wvalid_o  (m_axi_wvalid_o),
      .m_axi_wready_i  (m_axi_wready_i),
      .m_axi_bvalid_i  (m_axi_bvalid_i),
      .m_axi_bresp_i   (m_axi_bresp_i),
      .m_axi_bready_o  (m_axi_bready_o)
   );

endmodule
